// File: design/cpu_defines.svh
// width, register file and reset-PC macros for the pipelined core, included by every RTL file
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

// data word and byte address width
`define CPU_WORD_W 32

// register specifier width
`define CPU_REG_AW 5

// ----------------------------------------
// register file and reset
// ----------------------------------------

// general purpose registers, r0 reads zero
`define CPU_NUM_REGS 32

// first fetch address after reset, must be word aligned
`define CPU_PC_INIT 32'h0000_0000

`endif

// File: design/cpu_types_pkg.sv
// shared encodings and stage-boundary structs of the pipelined core, imported by each stage
`include "cpu_defines.svh"

package cpu_types_pkg;

  // basic datapath types
  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_REG_AW-1:0] regbits_t;

  // ----------------------------------------
  // instruction encodings
  // ----------------------------------------

  // major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type functs, instr[5:0]
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  // alu operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5
  } alu_op_t;

  // ----------------------------------------
  // control and stage registers
  // ----------------------------------------

  // decoded control, travels down the pipe with the instruction
  typedef struct packed {
    logic     reg_wen;
    regbits_t dest;
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     ext_sign;
    logic     mem_ren;
    logic     mem_wen;
    logic     beq;
    logic     bne;
    logic     jump;
    logic     halt;
  } ctrl_t;

  // fetch/decode
  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc_plus4;
  } fd_t;

  // decode/execute
  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    word_t       rdat1;
    word_t       rdat2;
    word_t       ext_imm;
    logic [25:0] jidx;
    word_t       pc_plus4;
  } de_t;

  // execute/memory
  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t alu_out;
    logic  zero;
    word_t store_data;
    word_t branch_target;
    word_t jump_target;
  } em_t;

  // memory/writeback
  typedef struct packed {
    logic     valid;
    logic     reg_wen;
    regbits_t dest;
    word_t    wdat;
    logic     halt;
  } mw_t;

endpackage

// File: design/fetch_stage.sv
// instruction fetch stage, holds the PC and loads the fetch/decode register for decode_stage
`include "cpu_defines.svh"

module fetch_stage import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  freeze,
  input  logic  stall,
  input  logic  halt,
  input  logic  redirect,
  input  word_t redirect_pc,
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_load,
  output fd_t   fd
);

  word_t pc;
  word_t pc_plus4;
  logic  run;

  assign pc_plus4 = pc + `CPU_WORD_W'(4);

  // request goes out from the first cycle after reset until halt
  assign imem_ren  = run & ~halt;
  assign imem_addr = pc;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // ----------------------------------------
  // pc and fetch/decode register
  // ----------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
      fd <= '0;
    end else if (!freeze) begin
      if (redirect) begin
        // taken branch or jump in mem, drop the fetched word
        pc       <= redirect_pc;
        fd.valid <= 1'b0;
      end else if (halt || !run) begin
        fd.valid <= 1'b0;
      end else if (!stall) begin
        pc          <= pc_plus4;
        fd.valid    <= 1'b1;
        fd.instr    <= imem_load;
        fd.pc_plus4 <= pc_plus4;
      end
      // stalled, pc and fd hold
    end
  end

endmodule

// File: design/decode_stage.sv
// decode stage with control decode, register file, hazard stall and the decode/execute register
`include "cpu_defines.svh"

module decode_stage import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     freeze,
  input  logic     flush,
  input  fd_t      fd,
  input  logic     em_busy,
  input  regbits_t em_dest,
  input  mw_t      mw,
  output logic     stall,
  output de_t      de
);

  opcode_t     op;
  funct_t      fn;
  regbits_t    rs;
  regbits_t    rt;
  regbits_t    rd;
  logic [15:0] imm;
  ctrl_t       ctrl;
  logic        uses_rs;
  logic        uses_rt;
  logic        hz_rs;
  logic        hz_rt;
  word_t       rdat1;
  word_t       rdat2;
  word_t       regs [`CPU_NUM_REGS];
  de_t         de_n;

  // instruction fields
  assign op  = opcode_t'(fd.instr[31:26]);
  assign fn  = funct_t'(fd.instr[5:0]);
  assign rs  = fd.instr[25:21];
  assign rt  = fd.instr[20:16];
  assign rd  = fd.instr[15:11];
  assign imm = fd.instr[15:0];

  // ----------------------------------------
  // control decode
  // ----------------------------------------
  always_comb begin
    ctrl    = '0;
    ctrl.alu_op = ALU_ADD;
    uses_rs = 1'b0;
    uses_rt = 1'b0;
    case (op)
      RTYPE: begin
        uses_rs      = 1'b1;
        uses_rt      = 1'b1;
        ctrl.dest    = rd;
        ctrl.reg_wen = 1'b1;
        case (fn)
          ADDU:    ctrl.alu_op = ALU_ADD;
          SUBU:    ctrl.alu_op = ALU_SUB;
          AND:     ctrl.alu_op = ALU_AND;
          OR:      ctrl.alu_op = ALU_OR;
          SLT:     ctrl.alu_op = ALU_SLT;
          // unknown funct acts as a nop
          default: ctrl.reg_wen = 1'b0;
        endcase
      end
      ADDIU, ORI, LUI, LW: begin
        uses_rs          = (op != LUI);
        ctrl.dest        = rt;
        ctrl.reg_wen     = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.ext_sign    = (op != ORI);
        ctrl.mem_ren     = (op == LW);
        if (op == ORI) ctrl.alu_op = ALU_OR;
        if (op == LUI) ctrl.alu_op = ALU_LUI;
      end
      SW: begin
        uses_rs          = 1'b1;
        uses_rt          = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.ext_sign    = 1'b1;
        ctrl.mem_wen     = 1'b1;
      end
      BEQ, BNE: begin
        // compare by subtract with a signed offset
        uses_rs       = 1'b1;
        uses_rt       = 1'b1;
        ctrl.alu_op   = ALU_SUB;
        ctrl.ext_sign = 1'b1;
        ctrl.beq      = (op == BEQ);
        ctrl.bne      = (op == BNE);
      end
      J:       ctrl.jump = 1'b1;
      HALT:    ctrl.halt = 1'b1;
      // unknown opcode acts as a nop
      default: ;
    endcase
    // r0 is never a destination, so no write and no hazard
    if (ctrl.dest == '0) ctrl.reg_wen = 1'b0;
  end

  // ----------------------------------------
  // register file with writeback on its write port
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (mw.valid && mw.reg_wen) regs[mw.dest] <= mw.wdat;
  end

  // same-cycle writeback passes through
  always_comb begin
    if (rs == '0) rdat1 = '0;
    else if (mw.valid && mw.reg_wen && mw.dest == rs) rdat1 = mw.wdat;
    else rdat1 = regs[rs];
    if (rt == '0) rdat2 = '0;
    else if (mw.valid && mw.reg_wen && mw.dest == rt) rdat2 = mw.wdat;
    else rdat2 = regs[rt];
  end

  // ----------------------------------------
  // hazard stall on writers in de or em
  // ----------------------------------------
  assign hz_rs = uses_rs && ((de.valid && de.ctrl.reg_wen && de.ctrl.dest == rs) ||
                             (em_busy && em_dest == rs));
  assign hz_rt = uses_rt && ((de.valid && de.ctrl.reg_wen && de.ctrl.dest == rt) ||
                             (em_busy && em_dest == rt));
  assign stall = fd.valid & (hz_rs | hz_rt);

  always_comb begin
    de_n.valid    = fd.valid & ~stall & ~flush;
    de_n.ctrl     = ctrl;
    de_n.rdat1    = rdat1;
    de_n.rdat2    = rdat2;
    // sign or zero extension of the immediate
    de_n.ext_imm  = {{16{ctrl.ext_sign & imm[15]}}, imm};
    de_n.jidx     = fd.instr[25:0];
    de_n.pc_plus4 = fd.pc_plus4;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      de <= '0;
    end else if (!freeze) begin
      de <= de_n;
    end
  end

  // writes into r0 are filtered at decode three stages back
  a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
    (mw.valid && mw.reg_wen) |-> (mw.dest != '0));

endmodule

// File: design/execute_stage.sv
// execute stage with ALU, zero flag, branch and jump targets and the execute/memory register
`include "cpu_defines.svh"

module execute_stage import cpu_types_pkg::*; (
  input  logic CLK,
  input  logic nRST,
  input  logic freeze,
  input  logic flush,
  input  de_t  de,
  output em_t  em
);

  word_t alu_a;
  word_t alu_b;
  word_t alu_out;
  em_t   em_n;

  // ----------------------------------------
  // alu
  // ----------------------------------------
  assign alu_a = de.rdat1;
  assign alu_b = de.ctrl.alu_src_imm ? de.ext_imm : de.rdat2;

  always_comb begin
    case (de.ctrl.alu_op)
      ALU_ADD: alu_out = alu_a + alu_b;
      ALU_SUB: alu_out = alu_a - alu_b;
      ALU_AND: alu_out = alu_a & alu_b;
      ALU_OR:  alu_out = alu_a | alu_b;
      // signed compare
      ALU_SLT: alu_out = {{(`CPU_WORD_W-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      // immediate into the upper half
      ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
      default: alu_out = '0;
    endcase
  end

  // ----------------------------------------
  // targets and execute/memory register
  // ----------------------------------------
  always_comb begin
    em_n.valid         = de.valid & ~flush;
    em_n.ctrl          = de.ctrl;
    em_n.alu_out       = alu_out;
    em_n.zero          = (alu_out == '0);
    em_n.store_data    = de.rdat2;
    // word offset relative to the next instruction
    em_n.branch_target = de.pc_plus4 + {de.ext_imm[`CPU_WORD_W-3:0], 2'b00};
    // region bits come from pc+4
    em_n.jump_target   = {de.pc_plus4[31:28], de.jidx, 2'b00};
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      em <= '0;
    end else if (!freeze) begin
      em <= em_n;
    end
  end

endmodule

// File: design/memory_stage.sv
// memory stage issuing data requests, resolving branches and loading the memory/writeback register
`include "cpu_defines.svh"

module memory_stage import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  freeze,
  input  em_t   em,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  output logic  redirect,
  output word_t redirect_pc,
  output mw_t   mw
);

  logic taken;
  mw_t  mw_n;

  // ----------------------------------------
  // data memory request
  // ----------------------------------------
  assign dmem_ren   = em.valid & em.ctrl.mem_ren;
  assign dmem_wen   = em.valid & em.ctrl.mem_wen;
  assign dmem_addr  = em.alu_out;
  assign dmem_store = em.store_data;

  // ----------------------------------------
  // branch and jump resolution
  // ----------------------------------------
  assign taken = em.valid & ((em.ctrl.beq & em.zero) |
                             (em.ctrl.bne & ~em.zero) |
                             em.ctrl.jump);

  // halt also drains the younger stages
  assign redirect    = taken | (em.valid & em.ctrl.halt);
  assign redirect_pc = em.ctrl.jump ? em.jump_target : em.branch_target;

  // ----------------------------------------
  // memory/writeback register
  // ----------------------------------------
  always_comb begin
    mw_n.valid   = em.valid;
    mw_n.reg_wen = em.ctrl.reg_wen;
    mw_n.dest    = em.ctrl.dest;
    mw_n.wdat    = em.ctrl.mem_ren ? dmem_load : em.alu_out;
    mw_n.halt    = em.ctrl.halt;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mw <= '0;
    end else if (!freeze) begin
      mw <= mw_n;
    end
  end

  // decode never sets both memory controls for one instruction
  a_one_dmem_req: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen));

endmodule

// File: design/pipeline_cpu.sv
// top of the five-stage core, wires the stages to the instruction and data memory ports
`include "cpu_defines.svh"

module pipeline_cpu import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic  CLK,
  input  logic  nRST,
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_load,
  input  logic  ihit,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  input  logic  dhit,
  output logic  halt
);

  fd_t   fd;
  de_t   de;
  em_t   em;
  mw_t   mw;
  logic  stall;
  logic  redirect;
  word_t redirect_pc;
  logic  freeze;
  logic  fetch_halt;
  // core side of the memory ports
  logic  core_iren;
  logic  core_dren;
  logic  core_dwen;
  word_t core_iload;
  word_t core_dload;
  // hits that came while the other port still waited
  logic  i_done;
  logic  d_done;
  word_t i_buf;
  word_t d_buf;

  // ----------------------------------------
  // memory ports and freeze
  // ----------------------------------------
  assign imem_ren = core_iren & ~i_done;
  assign dmem_ren = core_dren & ~d_done;
  assign dmem_wen = core_dwen & ~d_done;

  assign freeze = (imem_ren & ~ihit) | ((dmem_ren | dmem_wen) & ~dhit);

  assign core_iload = i_done ? i_buf : imem_load;
  assign core_dload = d_done ? d_buf : dmem_load;

  // an early hit is kept so the access is not repeated
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      i_done <= 1'b0;
      d_done <= 1'b0;
    end else if (!freeze) begin
      i_done <= 1'b0;
      d_done <= 1'b0;
    end else begin
      if (imem_ren && ihit) i_done <= 1'b1;
      if ((dmem_ren || dmem_wen) && dhit) d_done <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (freeze && imem_ren && ihit) i_buf <= imem_load;
    if (freeze && dmem_ren && dhit) d_buf <= dmem_load;
  end

  // ----------------------------------------
  // sticky halt
  // ----------------------------------------
  assign fetch_halt = halt | (mw.valid & mw.halt);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else begin
      halt <= halt | (mw.valid & mw.halt & ~freeze);
    end
  end

  // ----------------------------------------
  // stages
  // ----------------------------------------
  fetch_stage #(.PC_INIT(PC_INIT)) u_fetch (
    .CLK, .nRST, .freeze, .stall, .halt(fetch_halt), .redirect, .redirect_pc,
    .imem_ren(core_iren), .imem_addr, .imem_load(core_iload), .fd
  );

  decode_stage u_decode (
    .CLK, .nRST, .freeze, .flush(redirect), .fd,
    .em_busy(em.valid & em.ctrl.reg_wen), .em_dest(em.ctrl.dest),
    .mw, .stall, .de
  );

  execute_stage u_execute (
    .CLK, .nRST, .freeze, .flush(redirect), .de, .em
  );

  memory_stage u_memory (
    .CLK, .nRST, .freeze, .em, .dmem_ren(core_dren), .dmem_wen(core_dwen),
    .dmem_addr, .dmem_store, .dmem_load(core_dload), .redirect, .redirect_pc, .mw
  );

  // pc starts aligned and every target is a word offset
  a_imem_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    imem_ren |-> (imem_addr[1:0] == 2'b00));

endmodule

// File: test/isa_model.svh
// random program generator and instruction-level model of the core, included inside tb_cpu
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// ----------------------------------------
// program generator
// ----------------------------------------

// only r0..r7, so dependent pairs are frequent
function automatic void gen_program();
  int          i;
  int          tgt;
  int unsigned kind;
  regbits_t    rs;
  regbits_t    rt;
  regbits_t    dst;
  logic [15:0] imm;
  logic [5:0]  op;
  i = 0;
  // lui/ori pairs give r1..r7 a known value
  for (int k = 1; k < 8; k++) begin
    prog[i]     = {LUI, 5'd0, 5'(k), 16'($urandom)};
    prog[i + 1] = {ORI, 5'(k), 5'(k), 16'($urandom)};
    i += 2;
  end
  while (i < PROG_LEN - 1) begin
    kind = $urandom_range(11, 0);
    rs   = 5'($urandom_range(7, 0));
    rt   = 5'($urandom_range(7, 0));
    dst  = 5'($urandom_range(7, 0));
    imm  = 16'($urandom);
    case (kind)
      0:  prog[i] = {RTYPE, rs, rt, dst, 5'd0, ADDU};
      1:  prog[i] = {RTYPE, rs, rt, dst, 5'd0, SUBU};
      2:  prog[i] = {RTYPE, rs, rt, dst, 5'd0, AND};
      3:  prog[i] = {RTYPE, rs, rt, dst, 5'd0, OR};
      4:  prog[i] = {RTYPE, rs, rt, dst, 5'd0, SLT};
      5:  prog[i] = {ADDIU, rs, dst, imm};
      6:  prog[i] = {ORI, rs, dst, imm};
      7:  prog[i] = {LUI, 5'd0, dst, imm};
      // data accesses use r0 as base, word slots 0..63
      8:  prog[i] = {LW, 5'd0, dst, 8'd0, 6'($urandom_range(63, 0)), 2'b00};
      9:  prog[i] = {SW, 5'd0, rt, 8'd0, 6'($urandom_range(63, 0)), 2'b00};
      10: begin
        // equal operands now and then, so beq is taken and bne falls through
        if ($urandom_range(2, 0) == 0) rt = rs;
        op  = ($urandom_range(1, 0) == 1) ? BEQ : BNE;
        tgt = i + 1 + int'($urandom_range(4, 1));
        if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
        prog[i] = {op, rs, rt, 16'(tgt - i - 1)};
      end
      default: begin
        tgt = i + 1 + int'($urandom_range(4, 1));
        if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
        prog[i] = {J, 26'(BASE_W + tgt)};
      end
    endcase
    // store right behind a result makes it visible
    if (kind <= 8 && i + 1 < PROG_LEN - 1 && $urandom_range(1, 0) == 1) begin
      i++;
      prog[i] = {SW, 5'd0, dst, 8'd0, 6'($urandom_range(63, 0)), 2'b00};
    end
    i++;
  end
  prog[PROG_LEN - 1] = {HALT, 26'd0};
endfunction

// ----------------------------------------
// instruction-level model
// ----------------------------------------

// one instruction per step, stores go to the expected queues in order
function automatic void run_model();
  word_t    r [32];
  word_t    mem [DMEM_WORDS];
  word_t    ins;
  word_t    a;
  word_t    b;
  word_t    simm;
  word_t    addr;
  word_t    res;
  regbits_t wr;
  logic     wen;
  int       pc;
  int       steps;
  for (int k = 0; k < 32; k++) r[k] = '0;
  for (int k = 0; k < DMEM_WORDS; k++) mem[k] = dmem_fill(k);
  pc    = 0;
  steps = 0;
  // control flow only goes forward, so PROG_LEN steps are enough
  while (pc < PROG_LEN && steps < PROG_LEN) begin
    ins  = prog[pc];
    a    = r[ins[25:21]];
    b    = r[ins[20:16]];
    simm = {{16{ins[15]}}, ins[15:0]};
    addr = a + simm;
    wr   = ins[20:16];
    wen  = 1'b0;
    res  = '0;
    pc   = pc + 1;
    steps++;
    case (ins[31:26])
      RTYPE: begin
        wen = 1'b1;
        wr  = ins[15:11];
        case (ins[5:0])
          ADDU:    res = a + b;
          SUBU:    res = a - b;
          AND:     res = a & b;
          OR:      res = a | b;
          SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wen = 1'b0;
        endcase
      end
      ADDIU: begin
        wen = 1'b1;
        res = addr;
      end
      ORI: begin
        wen = 1'b1;
        res = a | {16'h0000, ins[15:0]};
      end
      LUI: begin
        wen = 1'b1;
        res = {ins[15:0], 16'h0000};
      end
      LW: begin
        wen = 1'b1;
        res = mem[addr[7:2]];
      end
      SW: begin
        mem[addr[7:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      // offsets count words from the next instruction
      BEQ:     if (a == b) pc = pc + int'(simm);
      BNE:     if (a != b) pc = pc + int'(simm);
      J:       pc = int'(ins[25:0]) - BASE_W;
      HALT:    pc = PROG_LEN;
      default: wen = 1'b0;
    endcase
    // r0 stays zero
    if (wen && wr != 5'd0) r[wr] = res;
  end
endfunction

`endif

// File: test/tb_cpu.sv
// testbench for pipeline_cpu, random program and memory latency, store stream checked against a model
`include "cpu_defines.svh"

module tb_cpu import cpu_types_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    PROG_LEN     = 200;
  localparam int    DMEM_WORDS   = 64;
  localparam word_t DMEM_BYTES   = 32'(4 * DMEM_WORDS);
  localparam word_t PC_BASE      = `CPU_PC_INIT;
  localparam int    BASE_W       = int'(PC_BASE >> 2);
  localparam int    MAX_CYCLES   = 20000;
  localparam int    DRAIN_CYCLES = 20;

  // dut ports
  logic  CLK;
  logic  nRST       = 1'b0;
  logic  imem_ren;
  word_t imem_addr;
  word_t imem_load  = '0;
  logic  ihit       = 1'b0;
  logic  dmem_ren;
  logic  dmem_wen;
  word_t dmem_addr;
  word_t dmem_store;
  word_t dmem_load  = '0;
  logic  dhit       = 1'b0;
  logic  halt;

  // program, data memory and expected stores
  word_t prog [PROG_LEN];
  word_t dmem [DMEM_WORDS];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    st_idx = 0;
  // cycles left before a hit, -1 when idle
  int    i_left;
  int    d_left;

  pipeline_cpu u_dut (
    .CLK, .nRST, .imem_ren, .imem_addr, .imem_load, .ihit,
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .dmem_load, .dhit, .halt
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // initial data, every address bit mixed in
  function automatic word_t dmem_fill(int idx);
    return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  // past the program end, halt words tagged with the address
  function automatic word_t imem_word(word_t addr);
    int idx;
    idx = int'((addr - PC_BASE) >> 2);
    if (addr >= PC_BASE && idx < PROG_LEN) return prog[idx];
    return {HALT, addr[27:2]};
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  // completes the pending data access, stores are checked in order
  task automatic serve_data();
    if (dmem_addr[1:0] != 2'b00 || dmem_addr >= DMEM_BYTES)
      abort_run($sformatf("data access outside the data memory at %h", dmem_addr));
    if (dmem_wen) begin
      if (st_idx >= exp_addr.size()) abort_run("more stores than the model predicts");
      compare_word("dmem_addr", dmem_addr, exp_addr[st_idx]);
      compare_word("dmem_store", dmem_store, exp_data[st_idx]);
      dmem[dmem_addr[7:2]] = dmem_store;
      st_idx++;
    end else begin
      dmem_load = dmem[dmem_addr[7:2]];
    end
  endtask

  `include "isa_model.svh"

  // ----------------------------------------
  // clock and memories
  // ----------------------------------------
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // requests are stable at the falling edge, hits go out 0..3 cycles later
  always @(negedge CLK) begin
    if (!nRST) begin
      ihit   = 1'b0;
      dhit   = 1'b0;
      i_left = -1;
      d_left = -1;
    end else begin
      ihit = 1'b0;
      dhit = 1'b0;
      // instruction port
      if (!imem_ren) begin
        i_left = -1;
      end else begin
        if (i_left < 0) i_left = int'($urandom_range(3, 0));
        if (i_left == 0) begin
          ihit      = 1'b1;
          imem_load = imem_word(imem_addr);
        end
        i_left--;
      end
      // data port
      if (!(dmem_ren || dmem_wen)) begin
        d_left = -1;
      end else begin
        if (d_left < 0) d_left = int'($urandom_range(3, 0));
        if (d_left == 0) begin
          dhit = 1'b1;
          serve_data();
        end
        d_left--;
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int unsigned seed_ret;
    int          cycles;
    seed_ret = $urandom(32'hf70eb7ed);
    gen_program();
    for (int k = 0; k < DMEM_WORDS; k++) dmem[k] = dmem_fill(k);
    run_model();

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // run until the core halts
    cycles = 0;
    while (!halt && cycles < MAX_CYCLES) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) abort_run("timeout waiting for halt");
    compare_word("store_count", word_t'(st_idx), word_t'(exp_addr.size()));

    // halted core stays quiet on both ports
    repeat (DRAIN_CYCLES) begin
      @(negedge CLK);
      if (!halt) abort_run("halt dropped after it was set");
      if (imem_ren || dmem_ren || dmem_wen) abort_run("memory request after halt");
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: all.f
+incdir+design
+incdir+test
design/cpu_types_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/pipeline_cpu.sv
test/tb_cpu.sv

// File: run.sh
#!/bin/sh
# build the pipelined core testbench with Verilator, then run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_cpu --Mdir obj_dir -o sim_cpu \
  -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./obj_dir/sim_cpu
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi

exit 0
